// ==== logic/clint_cfg.svh ====
/*
 * Build-time configuration of the CLINT
 * Hart count, mtime prescaler and request bus widths
 */
`ifndef CLINT_CFG_SVH
`define CLINT_CFG_SVH

// Number of harts served, two msip lanes per data word
`define CLINT_CPU_TOTAL 4

// Clock cycles per mtime increment, 1 means every cycle
`define CLINT_TICK_DIV 1

// Request address width, region field sits in the top two bits
`define CLINT_ADDR_BITS 16

// Request data width, one strobe bit per byte
`define CLINT_DATA_BITS 64

`endif

// ==== logic/clint_bus_pkg.sv ====
/*
 * Bus-side types of the CLINT
 * Sequencer state and address region decode
 */
package clint_bus_pkg;

    // Address bits 15:14 select the register region
    typedef enum logic [1:0] {
        REGION_MSIP     = 2'h0,    // Software interrupt pending bits
        REGION_MTIMECMP = 2'h1,    // Per-hart timer compare
        REGION_MTIME    = 2'h2,    // Free-running timer, read-only
        REGION_NONE     = 2'h3     // Unmapped, reads zero
    } clint_region_e;

    // One access in flight at a time
    typedef enum logic [1:0] {
        ST_IDLE   = 2'h0,          // Ready for a new request
        ST_ACCESS = 2'h1,          // Request strobed to the register bank
        ST_RESP   = 2'h2           // Read data presented with response valid
    } clint_state_e;

endpackage

// ==== logic/clint_hart_pkg.sv ====
/*
 * Hart-side types of the CLINT
 * Data word views, hart vector and register word index
 */
`include "clint_cfg.svh"

package clint_hart_pkg;

    // One data word, whole for mtime/mtimecmp or split into two msip lanes
    typedef union packed {
        logic [`CLINT_DATA_BITS-1:0]          dword;
        logic [1:0][`CLINT_DATA_BITS/2-1:0]   lane;    // Lane 0 is the low half
    } clint_word_u;

    // Word index taken from address bits 13:3
    typedef logic [10:0] clint_hart_idx_t;

    // One bit per hart
    typedef logic [`CLINT_CPU_TOTAL-1:0] clint_hart_vec_t;

endpackage

// ==== logic/clint_req_if.sv ====
/*
 * Single accepted access passed from the sequencer to the register bank
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

interface clint_req_if;

    logic                           strobe;    // One cycle per access
    logic                           write;
    logic [`CLINT_ADDR_BITS-1:0]    addr;
    logic [`CLINT_DATA_BITS-1:0]    wdata;
    logic [`CLINT_DATA_BITS/8-1:0]  wstrb;
    logic [`CLINT_DATA_BITS-1:0]    rdata;     // Latched by the bank

    modport fsm (
        output strobe, write, addr, wdata, wstrb,
        input  rdata
    );

    modport regs (
        input  strobe, write, addr, wdata, wstrb,
        output rdata
    );

endinterface

// ==== logic/clint_bus_fsm.sv ====
/*
 * Access sequencer that accepts one request, strobes it once to the
 * register bank and returns the latched read data as a one-cycle response
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

module clint_bus_fsm (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_req_valid,
    input  logic                          i_req_write,
    input  logic [`CLINT_ADDR_BITS-1:0]   i_req_addr,
    input  logic [`CLINT_DATA_BITS-1:0]   i_req_wdata,
    input  logic [`CLINT_DATA_BITS/8-1:0] i_req_wstrb,
    output logic                          o_req_ready,
    output logic                          o_resp_valid,
    output logic [`CLINT_DATA_BITS-1:0]   o_resp_rdata,
    clint_req_if.fsm                      bus
);
    import clint_bus_pkg::*;

    clint_state_e state;
    clint_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_req_valid) begin
                    state_next = ST_ACCESS;
                end
            end
            ST_ACCESS: state_next = ST_RESP;    // Bank acts at the end of this cycle
            ST_RESP:   state_next = ST_IDLE;
            default:   state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Request fields sampled at the accepting edge
    always_ff @(posedge i_clk) begin
        if (o_req_ready && i_req_valid) begin
            bus.write <= i_req_write;
            bus.addr  <= i_req_addr;
            bus.wdata <= i_req_wdata;
            bus.wstrb <= i_req_wstrb;
        end
    end

    assign o_req_ready  = (state == ST_IDLE);
    assign bus.strobe   = (state == ST_ACCESS);
    assign o_resp_valid = (state == ST_RESP);
    assign o_resp_rdata = bus.rdata;    // Held by the bank until the next access

    // Strobe only in the cycle after an accepted request
    a_strobe_after_accept: assert property (@(posedge i_clk) disable iff (!i_nrst)
        bus.strobe |-> $past(o_req_ready && i_req_valid));

    // Every strobe yields one response in the next cycle
    a_resp_after_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
        bus.strobe |=> o_resp_valid);

    a_resp_only_after_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |-> $past(bus.strobe));

endmodule

// ==== logic/clint_mtime_counter.sv ====
/*
 * Free-running 64-bit mtime counter advanced by a prescaled tick
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

module clint_mtime_counter (
    input  logic        i_clk,
    input  logic        i_nrst,
    output logic [63:0] o_mtime
);
    localparam int unsigned DIV = `CLINT_TICK_DIV;
    localparam int unsigned PW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic tick;

    generate
        if (DIV > 1) begin : g_presc
            logic [PW-1:0] presc_cnt;

            always_ff @(posedge i_clk or negedge i_nrst) begin
                if (!i_nrst) begin
                    presc_cnt <= '0;
                end else if (tick) begin
                    presc_cnt <= '0;    // Wrap at the divider
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end

            assign tick = (presc_cnt == PW'(DIV - 1));
        end else begin : g_no_presc
            assign tick = 1'b1;    // Advance every cycle
        end
    endgenerate

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_mtime <= 64'h0;
        end else if (tick) begin
            o_mtime <= o_mtime + 64'd1;
        end
    end

    // mtime holds or steps by one, never jumps
    a_mtime_step: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (o_mtime == $past(o_mtime)) || (o_mtime == $past(o_mtime) + 64'd1));

endmodule

// ==== logic/clint_hart_regs.sv ====
/*
 * Register bank with address decode, msip and mtimecmp per hart,
 * read data latch and registered timer compare
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

module clint_hart_regs (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic [63:0]                   i_mtime,
    clint_req_if.regs                     bus,
    output clint_hart_pkg::clint_hart_vec_t o_msip,
    output clint_hart_pkg::clint_hart_vec_t o_mtip
);
    import clint_bus_pkg::*;
    import clint_hart_pkg::*;

    localparam int unsigned CPU       = `CLINT_CPU_TOTAL;
    localparam int unsigned LANE_STRB = `CLINT_DATA_BITS / 16;    // Strobe bits per msip lane

    clint_region_e   region;
    clint_hart_idx_t idx;
    clint_word_u     wword;
    clint_word_u     rword;
    clint_hart_vec_t msip_we;
    clint_hart_vec_t cmp_we;
    logic [63:0]     mtimecmp [CPU];

    assign region = clint_region_e'(bus.addr[15:14]);
    assign idx    = bus.addr[13:3];
    assign wword  = bus.wdata;

    // Write enables active only in the strobe cycle
    // Out-of-range indexes match no hart
    always_comb begin
        for (int h = 0; h < CPU; h++) begin
            msip_we[h] = bus.strobe && bus.write && (region == REGION_MSIP)
                && (idx == clint_hart_idx_t'(h / 2))
                && (|bus.wstrb[LANE_STRB * (h % 2) +: LANE_STRB]);
            cmp_we[h]  = bus.strobe && bus.write && (region == REGION_MTIMECMP)
                && (idx == clint_hart_idx_t'(h));
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_msip <= '0;
            for (int h = 0; h < CPU; h++) begin
                mtimecmp[h] <= 64'h0;
            end
        end else begin
            for (int h = 0; h < CPU; h++) begin
                if (msip_we[h]) begin
                    o_msip[h] <= wword.lane[h % 2][0];    // Pending bit is lane bit 0
                end
                // Byte-wise update of the compare value
                for (int b = 0; b < `CLINT_DATA_BITS / 8; b++) begin
                    if (cmp_we[h] && bus.wstrb[b]) begin
                        mtimecmp[h][8*b +: 8] <= wword.dword[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read mux returns zero for unmapped words
    always_comb begin
        rword = '0;
        case (region)
            REGION_MSIP: begin
                for (int h = 0; h < CPU; h++) begin
                    if (idx == clint_hart_idx_t'(h / 2)) begin
                        rword.lane[h % 2][0] = o_msip[h];
                    end
                end
            end
            REGION_MTIMECMP: begin
                for (int h = 0; h < CPU; h++) begin
                    if (idx == clint_hart_idx_t'(h)) begin
                        rword.dword = mtimecmp[h];
                    end
                end
            end
            REGION_MTIME: begin
                if (idx == 11'h7ff) begin
                    rword.dword = i_mtime;    // Writes here are dropped
                end
            end
            default: begin
                rword = '0;
            end
        endcase
    end

    // Read data held for the response cycle
    always_ff @(posedge i_clk) begin
        if (bus.strobe) begin
            bus.rdata <= rword.dword;
        end
    end

    // Timer compare registered one cycle behind mtime
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_mtip <= '0;
        end else begin
            for (int h = 0; h < CPU; h++) begin
                o_mtip[h] <= (i_mtime >= mtimecmp[h]);
            end
        end
    end

    generate
        for (genvar g = 0; g < CPU; g++) begin : g_mtip_chk
            // Unwritten compare two steps ahead keeps the interrupt low two edges on
            a_mtip_below_cmp: assert property (@(posedge i_clk) disable iff (!i_nrst)
                (($past(i_mtime, 2) + 64'd1 < $past(mtimecmp[g], 2)) && !$past(cmp_we[g], 2))
                    |-> !o_mtip[g]);
        end
    endgenerate

endmodule

// ==== logic/clint_top.sv ====
/*
 * CLINT top level with plain request/response ports and per-hart interrupts
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

module clint_top (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    input  logic                          i_req_valid,
    input  logic                          i_req_write,
    input  logic [`CLINT_ADDR_BITS-1:0]   i_req_addr,
    input  logic [`CLINT_DATA_BITS-1:0]   i_req_wdata,
    input  logic [`CLINT_DATA_BITS/8-1:0] i_req_wstrb,
    output logic                          o_req_ready,
    output logic                          o_resp_valid,
    output logic [`CLINT_DATA_BITS-1:0]   o_resp_rdata,
    output logic [63:0]                   o_mtimer,     // Shadow copy of mtime for the harts
    output logic [`CLINT_CPU_TOTAL-1:0]   o_msip,
    output logic [`CLINT_CPU_TOTAL-1:0]   o_mtip
);

    logic [63:0] mtime;

    clint_req_if req_bus ();

    clint_bus_fsm u_bus_fsm (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (i_req_valid),
        .i_req_write  (i_req_write),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_wstrb  (i_req_wstrb),
        .o_req_ready  (o_req_ready),
        .o_resp_valid (o_resp_valid),
        .o_resp_rdata (o_resp_rdata),
        .bus          (req_bus.fsm)
    );

    clint_mtime_counter u_mtime (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .o_mtime (mtime)
    );

    clint_hart_regs u_hart_regs (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_mtime (mtime),
        .bus     (req_bus.regs),
        .o_msip  (o_msip),
        .o_mtip  (o_mtip)
    );

    assign o_mtimer = mtime;

endmodule

// ==== tests/clint_clkgen.sv ====
/*
 * Testbench clock and active-low reset generator
 */
`timescale 1ns/1ps

module clint_clkgen #(
    parameter real PERIOD_NS  = 8.0,
    parameter int  RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_nrst
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    initial begin
        o_nrst = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;    // Released away from the sampling edge
    end

endmodule

// ==== tests/clint_tb.sv ====
/*
 * Directed CLINT testbench with a register map model,
 * error counting and a cycle timeout
 */
`timescale 1ns/1ps
`include "clint_cfg.svh"

module clint_tb;
    import clint_bus_pkg::*;

    localparam int CPU   = `CLINT_CPU_TOTAL;
    localparam int DIV   = `CLINT_TICK_DIV;
    localparam int WORDS = (CPU + 1) / 2;    // msip words in use
    localparam int ACCESSES = (CPU + WORDS + 1) + (8 * 2 + WORDS) + (CPU * 3 * 2 + 4 + CPU)
        + 3 + CPU * 2 + 2;
    localparam int TIMEOUT_CYCLES = ACCESSES * 4 + CPU * (64 * DIV + 16) + 10 * DIV + 100;

    logic        clk;
    logic        nrst;
    logic        i_req_valid;
    logic        i_req_write;
    logic [15:0] i_req_addr;
    logic [63:0] i_req_wdata;
    logic [7:0]  i_req_wstrb;
    logic        o_req_ready;
    logic        o_resp_valid;
    logic [63:0] o_resp_rdata;
    logic [63:0] o_mtimer;
    logic [CPU-1:0] o_msip;
    logic [CPU-1:0] o_mtip;

    logic [CPU-1:0] exp_msip;         // Reference model state
    logic [63:0]    exp_cmp [CPU];
    int     errors   = 0;
    int     accesses = 0;
    int     cycles   = 0;
    integer seed     = 32'h62392167;

    clint_clkgen u_clkgen (.o_clk(clk), .o_nrst(nrst));

    clint_top uut (
        .i_clk(clk), .i_nrst(nrst), .i_req_valid(i_req_valid), .i_req_write(i_req_write),
        .i_req_addr(i_req_addr), .i_req_wdata(i_req_wdata), .i_req_wstrb(i_req_wstrb),
        .o_req_ready(o_req_ready), .o_resp_valid(o_resp_valid), .o_resp_rdata(o_resp_rdata),
        .o_mtimer(o_mtimer), .o_msip(o_msip), .o_mtip(o_mtip)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Accesses: %0d, errors: %0d", accesses, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    function automatic logic [15:0] make_addr(input clint_region_e r, input logic [10:0] idx);
        return {r, idx, 3'b000};
    endfunction

    // Register map rules applied to the model
    function automatic logic [63:0] expected_read(input clint_region_e r,
                                                  input logic [10:0] idx);
        logic [63:0] v;
        int w;
        v = 64'h0;
        w = int'(idx);
        if (r == REGION_MSIP) begin
            for (int l = 0; l < 2; l++) begin
                if (2 * w + l < CPU) v[32 * l] = exp_msip[2 * w + l];
            end
        end else if (r == REGION_MTIMECMP && w < CPU) begin
            v = exp_cmp[w];
        end
        return v;
    endfunction

    // One access on the falling edge; hold keeps i_req_valid up through the busy cycles
    task automatic run_access(input logic wr, input logic [15:0] addr, input logic [63:0] wdata,
                              input logic [7:0] wstrb, input bit hold, output logic [63:0] rdata);
        int lat;
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req_write = wr;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_wstrb = wstrb;
        while (o_req_ready !== 1'b1) @(negedge clk);
        accesses++;
        lat = 0;    // Falling edges since the accepting edge
        do begin
            @(negedge clk);
            lat++;
            if (!hold) i_req_valid = 1'b0;
            if (o_req_ready !== 1'b0) report_mismatch("o_req_ready", 64'(o_req_ready), 64'h0);
        end while (o_resp_valid !== 1'b1 && lat < 6);
        if (o_resp_valid !== 1'b1) begin
            $display("%0t ns: no response within %0d cycles of acceptance", $time, lat);
            errors++;
        end else if (lat != 2) begin
            report_mismatch("response latency", 64'(lat), 64'd2);
        end
        rdata = o_resp_rdata;
        @(negedge clk);
        i_req_valid = 1'b0;
        if (o_resp_valid !== 1'b0) report_mismatch("o_resp_valid", 64'(o_resp_valid), 64'h0);
        if (o_req_ready !== 1'b1) report_mismatch("o_req_ready", 64'(o_req_ready), 64'h1);
    endtask

    task automatic write_access(input clint_region_e r, input logic [10:0] idx,
                                input logic [63:0] wdata, input logic [7:0] wstrb);
        logic [63:0] ignored;
        int w;
        run_access(1'b1, make_addr(r, idx), wdata, wstrb, 1'b0, ignored);
        w = int'(idx);
        if (r == REGION_MSIP) begin
            for (int l = 0; l < 2; l++) begin    // A lane is written if any byte of its half is
                if (2 * w + l < CPU && |wstrb[4 * l +: 4]) exp_msip[2 * w + l] = wdata[32 * l];
            end
        end else if (r == REGION_MTIMECMP && w < CPU) begin
            for (int b = 0; b < 8; b++) begin
                if (wstrb[b]) exp_cmp[w][8 * b +: 8] = wdata[8 * b +: 8];
            end
        end
    endtask

    task automatic read_access(input clint_region_e r, input logic [10:0] idx, input bit hold);
        logic [63:0] rdata;
        logic [63:0] exp;
        exp = expected_read(r, idx);
        run_access(1'b0, make_addr(r, idx), 64'h0, 8'h00, hold, rdata);
        if (rdata !== exp) begin
            report_mismatch($sformatf("o_resp_rdata %s[0x%0h]", r.name(), idx), rdata, exp);
        end
    endtask

    task automatic check_reset_state();
        if (o_msip !== '0) report_mismatch("o_msip", 64'(o_msip), 64'h0);
        if (o_resp_valid !== 1'b0) report_mismatch("o_resp_valid", 64'(o_resp_valid), 64'h0);
        if (o_req_ready !== 1'b1) report_mismatch("o_req_ready", 64'(o_req_ready), 64'h1);
        for (int h = 0; h < CPU; h++) read_access(REGION_MTIMECMP, 11'(h), 1'b0);
        for (int w = 0; w < WORDS; w++) read_access(REGION_MSIP, 11'(w), 1'b0);
        read_access(REGION_NONE, 11'h0, 1'b0);
    endtask

    task automatic check_software_irq();
        logic [63:0] wdata;
        logic [7:0]  wstrb;
        logic [10:0] w;
        for (int k = 0; k < 8; k++) begin
            w     = 11'($unsigned($random(seed)) % (WORDS + 1));    // One word past the harts
            wdata = {$random(seed), $random(seed)};
            wstrb = 8'($random(seed)) & {{4{1'($random(seed))}}, {4{1'($random(seed))}}};
            write_access(REGION_MSIP, w, wdata, wstrb);
            if (o_msip !== exp_msip) report_mismatch("o_msip", 64'(o_msip), 64'(exp_msip));
            read_access(REGION_MSIP, w, 1'b0);
        end
        for (int i = 0; i < WORDS; i++) read_access(REGION_MSIP, 11'(i), 1'b0);
    endtask

    task automatic check_mtimecmp_strobes();
        for (int h = 0; h < CPU; h++) begin
            for (int k = 0; k < 3; k++) begin
                write_access(REGION_MTIMECMP, 11'(h), {$random(seed), $random(seed)},
                             8'($random(seed)));
                read_access(REGION_MTIMECMP, 11'(h), 1'b0);
            end
        end
        // Indexes past the last hart
        write_access(REGION_MTIMECMP, 11'(CPU), {$random(seed), $random(seed)}, 8'hff);
        read_access(REGION_MTIMECMP, 11'(CPU), 1'b0);
        write_access(REGION_MTIMECMP, 11'h7fe, {$random(seed), $random(seed)}, 8'hff);
        read_access(REGION_MTIMECMP, 11'h7fe, 1'b0);
        for (int h = 0; h < CPU; h++) read_access(REGION_MTIMECMP, 11'(h), 1'b0);
    endtask

    task automatic check_mtime();
        logic [63:0] t0;
        logic [63:0] t1;
        logic [63:0] r;
        logic [63:0] m0;
        logic [63:0] prev;
        for (int k = 0; k < 2; k++) begin
            t0 = o_mtimer;
            run_access(1'b0, make_addr(REGION_MTIME, 11'h7ff), 64'h0, 8'h00, 1'b0, r);
            t1 = o_mtimer;
            if (r < t0 || r > t1) begin
                $display("[ERROR] %0t ns o_resp_rdata: mtime read %h outside %h..%h",
                         $time, r, t0, t1);
                errors++;
            end
            if (k == 0) begin
                write_access(REGION_MTIME, 11'h7ff, {$random(seed), $random(seed)}, 8'hff);
                m0   = o_mtimer;
                prev = m0;
                repeat (10 * DIV) begin
                    @(negedge clk);
                    if (o_mtimer !== prev && o_mtimer !== prev + 64'd1) begin
                        report_mismatch("o_mtimer step", o_mtimer, prev + 64'd1);
                    end
                    prev = o_mtimer;
                end
                if (o_mtimer !== m0 + 64'd10) report_mismatch("o_mtimer", o_mtimer, m0 + 64'd10);
            end
        end
    endtask

    task automatic check_timer_irq();
        logic [63:0] target;
        int offset;
        bit seen;
        for (int h = 0; h < CPU; h++) begin
            offset = 20 + int'($unsigned($random(seed)) % 41);
            target = o_mtimer + 64'(offset);
            write_access(REGION_MTIMECMP, 11'(h), target, 8'hff);
            while (o_mtimer < target) begin
                if (o_mtip[h] !== 1'b0) begin
                    report_mismatch($sformatf("o_mtip[%0d]", h), 64'(o_mtip[h]), 64'h0);
                end
                @(negedge clk);
            end
            seen = (o_mtip[h] === 1'b1);
            for (int k = 0; k < 2 && !seen; k++) begin
                @(negedge clk);
                seen = (o_mtip[h] === 1'b1);
            end
            if (!seen) begin
                $display("%0t ns: o_mtip[%0d] did not rise after mtime reached mtimecmp",
                         $time, h);
                errors++;
            end
            write_access(REGION_MTIMECMP, 11'(h), o_mtimer + 64'h1_0000_0000, 8'hff);
            repeat (3) begin    // Compare far ahead, interrupt stays clear
                if (o_mtip[h] !== 1'b0) begin
                    report_mismatch($sformatf("o_mtip[%0d]", h), 64'(o_mtip[h]), 64'h0);
                end
                @(negedge clk);
            end
        end
    endtask

    task automatic check_handshake();
        for (int h = 0; h < 2; h++) begin
            read_access(REGION_MTIMECMP, 11'(h % CPU), 1'b1);
            repeat (6) begin
                @(negedge clk);
                if (o_resp_valid !== 1'b0) begin
                    $display("%0t ns: held request was accepted more than once", $time);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        i_req_addr  = 16'h0;
        i_req_wdata = 64'h0;
        i_req_wstrb = 8'h0;
        exp_msip    = '0;
        for (int h = 0; h < CPU; h++) exp_cmp[h] = 64'h0;
        @(posedge nrst);
        @(negedge clk);
        check_reset_state();
        check_software_irq();
        check_mtimecmp_strobes();
        check_mtime();
        check_timer_irq();
        check_handshake();
        $display("Accesses: %0d, errors: %0d", accesses, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/clint_bus_pkg.sv
logic/clint_hart_pkg.sv
logic/clint_req_if.sv
logic/clint_bus_fsm.sv
logic/clint_mtime_counter.sv
logic/clint_hart_regs.sv
logic/clint_top.sv
tests/clint_clkgen.sv
tests/clint_tb.sv

// ==== Makefile ====
# Verilator build and run for the CLINT testbench

VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FILELIST)) logic/clint_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -qx '$(PASS_MSG)' $(LOG); then echo "PASS"; else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
